// File: flist.f
hw/ts2asi_pkg.sv
hw/ts_fifo.sv
hw/asi_framer.sv
hw/enc_8b10b.sv
hw/asi_serializer.sv
hw/ts2asi.sv
verification/asi_rx_model.sv
verification/tb_ts2asi.sv

// File: hw/asi_framer.sv
`default_nettype none

module asi_framer #(
	parameter int packet_len = 188
) (
	input wire din_clk,
	input wire rst_n,
	input wire fifo_valid,
	input wire [ts2asi_pkg::byte_w-1:0] fifo_data,
	input wire char_ready,
	output logic fifo_ready,
	output logic char_valid,
	output logic [ts2asi_pkg::byte_w-1:0] char_data,
	output logic char_k
);

	localparam int cnt_w = $clog2(packet_len + 1);
	localparam int owe_w = $clog2(ts2asi_pkg::sync_commas + 1);

	logic [cnt_w-1:0] byte_cnt;
	logic [owe_w-1:0] owed;
	logic take;
	logic last_byte;

	// Register refills whenever it is empty or being emptied
	assign take = !char_valid || char_ready;

	// Owed sync commas win over data
	assign fifo_ready = take && (owed == '0);

	assign last_byte = (byte_cnt == cnt_w'(packet_len - 1));

	always_ff @(posedge din_clk) begin
		if (take) begin
			if (fifo_ready && fifo_valid) begin
				char_data <= fifo_data;
				char_k <= 1'b0;
			end else begin
				char_data <= ts2asi_pkg::k28_5_byte;
				char_k <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Packet count and sync debt
	////////////////////////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			char_valid <= 1'b0;
			byte_cnt <= '0;
			owed <= owe_w'(ts2asi_pkg::sync_commas);
		end else if (take) begin
			char_valid <= 1'b1;
			if (owed != '0) begin
				owed <= owed - 1'b1;
			end else if (fifo_valid) begin
				if (last_byte) begin
					byte_cnt <= '0;
					owed <= owe_w'(ts2asi_pkg::sync_commas);
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/asi_serializer.sv
`default_nettype none

module asi_serializer (
	input wire din_clk,
	input wire rst_n,
	input wire sym_valid,
	input wire [ts2asi_pkg::sym_w-1:0] sym_data,
	output logic sym_ready,
	output logic sout
);

	localparam int cnt_w = ts2asi_pkg::sym_cnt_w;

	logic [ts2asi_pkg::sym_w-1:0] shift_r;
	logic [cnt_w-1:0] bit_cnt;
	logic loaded;
	logic last_bit;

	assign last_bit = (bit_cnt == cnt_w'(ts2asi_pkg::sym_w - 1));

	// Asks every cycle until the first symbol, then once per symbol
	assign sym_ready = !loaded || last_bit;

	assign sout = shift_r[0];

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			shift_r <= '0;
			bit_cnt <= '0;
			loaded <= 1'b0;
		end else if (sym_ready && sym_valid) begin
			shift_r <= sym_data;
			bit_cnt <= '0;
			loaded <= 1'b1;
		end else if (loaded) begin
			// LSB first
			shift_r <= {1'b0, shift_r[ts2asi_pkg::sym_w-1:1]};
			bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/enc_8b10b.sv
`default_nettype none

module enc_8b10b (
	input wire din_clk,
	input wire rst_n,
	input wire char_valid,
	input wire [ts2asi_pkg::byte_w-1:0] char_data,
	input wire char_k,
	input wire sym_ready,
	output logic char_ready,
	output logic sym_valid,
	output logic [ts2asi_pkg::sym_w-1:0] sym_data
);

	// Running disparity, high means positive
	logic rd;
	logic rd6;
	logic rd_next;
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6_n;
	logic [5:0] c6;
	logic [3:0] c4_n;
	logic [3:0] c4;
	logic unbal6;
	logic unbal4;
	logic alt7;
	logic [ts2asi_pkg::sym_w-1:0] abcd;
	logic [ts2asi_pkg::sym_w-1:0] sym_next;

	////////////////////////////////////////
	// Code tables, RD- column, a on the left
	////////////////////////////////////////

	function automatic logic [5:0] enc6_rdn(input logic [4:0] v);
		logic [5:0] t [32];
		t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001,
			6'b110101, 6'b101001, 6'b011001, 6'b111000,
			6'b111001, 6'b100101, 6'b010101, 6'b110100,
			6'b001101, 6'b101100, 6'b011100, 6'b010111,
			6'b011011, 6'b100011, 6'b010011, 6'b110010,
			6'b001011, 6'b101010, 6'b011010, 6'b111010,
			6'b110011, 6'b100110, 6'b010110, 6'b110110,
			6'b001110, 6'b101110, 6'b011110, 6'b101011};
		return t[v];
	endfunction

	function automatic logic [3:0] enc4_rdn(input logic [2:0] v);
		logic [3:0] t [8];
		t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100,
			4'b1101, 4'b1010, 4'b0110, 4'b1110};
		return t[v];
	endfunction

	assign x = char_data[4:0];
	assign y = char_data[7:5];

	always_comb begin
		// 5b/6b subblock, D.7 flips although balanced
		c6_n = enc6_rdn(x);
		unbal6 = ($countones(c6_n) != 3);
		c6 = (rd && (unbal6 || x == 5'd7)) ? ~c6_n : c6_n;
		rd6 = rd ^ unbal6;

		// Alternate D.x.7 avoids a run of five
		alt7 = (y == 3'd7) &&
			((!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
		c4_n = alt7 ? 4'b0111 : enc4_rdn(y);
		unbal4 = ($countones(c4_n) != 2);
		c4 = (rd6 && (unbal4 || y == 3'd3)) ? ~c4_n : c4_n;

		// Wire order puts a in bit 0
		abcd = {c6, c4};
		for (int i = 0; i < ts2asi_pkg::sym_w; i++) begin
			sym_next[i] = abcd[ts2asi_pkg::sym_w-1-i];
		end
		rd_next = rd6 ^ unbal4;

		// Comma flips disparity every time
		if (char_k) begin
			sym_next = rd ? ts2asi_pkg::k28_5_rdp : ts2asi_pkg::k28_5_rdn;
			rd_next = !rd;
		end
	end

	assign char_ready = !sym_valid || sym_ready;

	always_ff @(posedge din_clk) begin
		if (char_valid && char_ready) begin
			sym_data <= sym_next;
		end
	end

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			sym_valid <= 1'b0;
			rd <= 1'b0;
		end else if (char_valid && char_ready) begin
			sym_valid <= 1'b1;
			rd <= rd_next;
		end else if (sym_ready) begin
			sym_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/ts2asi.sv
`default_nettype none

module ts2asi #(
	parameter int fifo_depth = 16,
	parameter int packet_len = 188
) (
	input wire din_clk,
	input wire rst_n,
	input wire valid,
	input wire [ts2asi_pkg::byte_w-1:0] din_8b,
	output logic asi_out_p,
	output logic asi_out_n,
	output logic error_full
);

	logic fifo_valid;
	logic fifo_ready;
	logic [ts2asi_pkg::byte_w-1:0] fifo_data;
	logic char_valid;
	logic char_ready;
	logic [ts2asi_pkg::byte_w-1:0] char_data;
	logic char_k;
	logic sym_valid;
	logic sym_ready;
	logic [ts2asi_pkg::sym_w-1:0] sym_data;
	logic sout;

	////////////////////////////////////////
	// Byte buffer
	////////////////////////////////////////

	ts_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.valid(valid),
		.din_8b(din_8b),
		.fifo_ready(fifo_ready),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.error_full(error_full)
	);

	// Data or comma, sync after each packet
	asi_framer #(
		.packet_len(packet_len)
	) u_framer (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.char_ready(char_ready),
		.fifo_ready(fifo_ready),
		.char_valid(char_valid),
		.char_data(char_data),
		.char_k(char_k)
	);

	////////////////////////////////////////
	// Line coding and output
	////////////////////////////////////////

	enc_8b10b u_enc (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.char_valid(char_valid),
		.char_data(char_data),
		.char_k(char_k),
		.sym_ready(sym_ready),
		.char_ready(char_ready),
		.sym_valid(sym_valid),
		.sym_data(sym_data)
	);

	asi_serializer u_ser (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.sym_valid(sym_valid),
		.sym_data(sym_data),
		.sym_ready(sym_ready),
		.sout(sout)
	);

	// Differential pair
	assign asi_out_p = sout;
	assign asi_out_n = ~sout;

endmodule

`default_nettype wire

// File: hw/ts2asi_pkg.sv
`default_nettype none

package ts2asi_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// One transport stream byte
	localparam int byte_w = 8;

	// One 8b/10b symbol
	localparam int sym_w = 10;

	// Bit counter inside the serializer
	localparam int sym_cnt_w = $clog2(sym_w);

	////////////////////////////////////////
	// Comma character
	////////////////////////////////////////

	// K28.5 as a byte, marked by the control flag
	localparam logic [byte_w-1:0] k28_5_byte = 8'hbc;

	// Bit 0 goes out first, so abcdei fghj = 001111 1010 reads backwards here
	localparam logic [sym_w-1:0] k28_5_rdn = 10'b0101111100;

	// Positive disparity form, the complement of the one above
	localparam logic [sym_w-1:0] k28_5_rdp = 10'b1010000011;

	// Commas forced after each full packet
	localparam int sync_commas = 2;

endpackage

`default_nettype wire

// File: hw/ts_fifo.sv
`default_nettype none

module ts_fifo #(
	parameter int fifo_depth = 16
) (
	input wire din_clk,
	input wire rst_n,
	input wire valid,
	input wire [ts2asi_pkg::byte_w-1:0] din_8b,
	input wire fifo_ready,
	output logic fifo_valid,
	output logic [ts2asi_pkg::byte_w-1:0] fifo_data,
	output logic error_full
);

	localparam int addr_w = $clog2(fifo_depth);

	logic [ts2asi_pkg::byte_w-1:0] mem [fifo_depth];

	// Extra top bit tells full from empty
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;
	logic full;
	logic empty;
	logic wr_en;
	logic rd_en;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
		(wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

	assign wr_en = valid && !full;
	assign rd_en = fifo_valid && fifo_ready;

	assign fifo_valid = !empty;
	assign fifo_data = mem[rd_ptr[addr_w-1:0]];

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge din_clk) begin
		if (wr_en) begin
			mem[wr_ptr[addr_w-1:0]] <= din_8b;
		end
	end

	////////////////////////////////////////
	// Pointers and overflow flag
	////////////////////////////////////////

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			error_full <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Byte lost, flag sticks until reset
			if (valid && full) begin
				error_full <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module tb_ts2asi -f flist.f -o Vtb_ts2asi

./obj_dir/Vtb_ts2asi > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

// File: verification/asi_rx_model.sv
`default_nettype none

module asi_rx_model (
	input wire din_clk,
	input wire rst_n,
	input wire line,
	output logic rx_strobe,
	output logic [7:0] rx_byte,
	output logic rx_k,
	output logic rx_legal
);

	timeunit 1ns;
	timeprecision 100ps;

	// Standard 5b/6b and 3b/4b codes for RD-, written abcdei and fghj
	localparam logic [5:0] six_tab [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [3:0] four_tab [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	logic [9:0] sr;
	logic [3:0] bit_cnt;
	logic aligned;
	logic rd;

	// Symbol as it appears on the wire, a in bit 0
	function automatic logic [9:0] encode(input logic [7:0] b, input logic rd_in);
		logic [5:0] s6;
		logic [3:0] s4;
		logic rd_mid;
		logic alt;
		s6 = six_tab[b[4:0]];
		rd_mid = rd_in ^ ($countones(s6) != 3);
		if (rd_in && ($countones(s6) != 3 || b[4:0] == 5'd7)) begin
			s6 = ~s6;
		end
		alt = (b[7:5] == 3'd7) && (rd_mid ? (b[4:0] inside {5'd11, 5'd13, 5'd14}) :
			(b[4:0] inside {5'd17, 5'd18, 5'd20}));
		s4 = alt ? 4'b0111 : four_tab[b[7:5]];
		if (rd_mid && ($countones(s4) != 2 || b[7:5] == 3'd3)) begin
			s4 = ~s4;
		end
		return {<<{s6, s4}};
	endfunction

	always @(negedge din_clk) begin
		logic [9:0] word;
		logic found;
		logic [7:0] val;
		int v;
		word = {line, sr[9:1]};
		found = 1'b0;
		val = '0;
		sr <= word;
		rx_strobe <= 1'b0;
		if (!rst_n) begin
			aligned <= 1'b0;
			bit_cnt <= '0;
			rd <= 1'b0;
		end else if (!aligned) begin
			// First comma fixes the symbol boundary
			if (word == ts2asi_pkg::k28_5_rdn || word == ts2asi_pkg::k28_5_rdp) begin
				aligned <= 1'b1;
				bit_cnt <= '0;
				rd <= (word == ts2asi_pkg::k28_5_rdn);
				rx_strobe <= 1'b1;
				rx_byte <= ts2asi_pkg::k28_5_byte;
				rx_k <= 1'b1;
				rx_legal <= 1'b1;
			end
		end else if (bit_cnt == 4'd9) begin
			bit_cnt <= '0;
			if (word == (rd ? ts2asi_pkg::k28_5_rdp : ts2asi_pkg::k28_5_rdn)) begin
				found = 1'b1;
				val = ts2asi_pkg::k28_5_byte;
				rx_k <= 1'b1;
			end else begin
				rx_k <= 1'b0;
				// Only a code legal for the current disparity matches
				for (v = 0; v < 256; v++) begin
					if (!found && encode(v[7:0], rd) == word) begin
						found = 1'b1;
						val = v[7:0];
					end
				end
			end
			rx_strobe <= 1'b1;
			rx_byte <= val;
			rx_legal <= found;
			if ($countones(word) != 5) begin
				rd <= ($countones(word) == 6);
			end
		end else begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_ts2asi.sv
`default_nettype none

module tb_ts2asi;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int fifo_depth = 16;
	localparam int packet_len = 12;
	localparam int paced_bytes = 48;
	localparam int burst_bytes = 40;

	logic din_clk;
	logic rst_n;
	logic valid;
	logic [7:0] din_8b;
	wire asi_out_p;
	wire asi_out_n;
	wire error_full;
	wire rx_strobe;
	wire [7:0] rx_byte;
	wire rx_k;
	wire rx_legal;

	logic [7:0] exp_q [$];
	logic burst_phase;
	logic seen_full;
	int data_run;
	int comma_run;
	int burst_rx;

	ts2asi #(
		.fifo_depth(fifo_depth),
		.packet_len(packet_len)
	) dut (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.valid(valid),
		.din_8b(din_8b),
		.asi_out_p(asi_out_p),
		.asi_out_n(asi_out_n),
		.error_full(error_full)
	);

	asi_rx_model rx (
		.din_clk(din_clk),
		.rst_n(rst_n),
		.line(asi_out_p),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte),
		.rx_k(rx_k),
		.rx_legal(rx_legal)
	);

	initial begin
		din_clk = 1'b0;
		forever #2 din_clk = ~din_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge din_clk);
		#1;
	endtask

	task automatic offer_byte(input logic [7:0] b);
		valid = 1'b1;
		din_8b = b;
		exp_q.push_back(b);
		step();
	endtask

	// Exact order while paced, subsequence once bytes may drop
	task automatic score_byte(input logic [7:0] b);
		if (!burst_phase) begin
			if (exp_q.size() == 0) begin
				stop_run("decoded a data byte that was never offered");
			end else begin
				check_eq("rx data byte", b, exp_q.pop_front());
			end
		end else begin
			while (exp_q.size() != 0 && exp_q[0] != b) begin
				void'(exp_q.pop_front());
			end
			if (exp_q.size() == 0) begin
				stop_run("decoded burst byte is out of the offered order");
			end else begin
				void'(exp_q.pop_front());
				burst_rx++;
			end
		end
	endtask

	////////////////////////////////////////
	// Scoreboard
	////////////////////////////////////////

	always @(posedge din_clk) begin
		if (rst_n && rx_strobe) begin
			check_eq("rx_legal", rx_legal, 1);
			if (rx_k) begin
				comma_run++;
			end else begin
				// A pair of commas closes the packet
				if (comma_run >= ts2asi_pkg::sync_commas) begin
					data_run = 0;
				end
				comma_run = 0;
				data_run++;
				if (data_run > packet_len) begin
					stop_run("more than packet_len data characters without sync commas");
				end else begin
					score_byte(rx_byte);
				end
			end
		end
		if (rst_n) begin
			if (!burst_phase) begin
				check_eq("error_full", error_full, 0);
			end else if (seen_full) begin
				check_eq("error_full", error_full, 1);
			end
			if (error_full) begin
				seen_full = 1'b1;
			end
		end
	end

	always @(negedge din_clk) begin
		if (rst_n) begin
			check_eq("asi_out_n", asi_out_n, !asi_out_p);
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		int gap;
		int waited;
		int quiet;
		int last_rx;
		valid = 1'b0;
		din_8b = '0;
		rst_n = 1'b0;
		burst_phase = 1'b0;
		seen_full = 1'b0;
		data_run = 0;
		comma_run = 0;
		burst_rx = 0;
		void'($urandom(86262));
		repeat (4) @(posedge din_clk);
		#1;
		rst_n = 1'b1;

		// Gaps of 14 or more stay under the line rate
		for (int i = 0; i < paced_bytes; i++) begin
			offer_byte($urandom_range(0, 255));
			valid = 1'b0;
			gap = $urandom_range(14, 22);
			repeat (gap - 1) step();
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < 3000) begin
			step();
			waited++;
		end
		if (exp_q.size() != 0) begin
			stop_run("timeout while waiting for paced bytes on the line");
		end

		// Back to back bytes overrun the FIFO
		burst_phase = 1'b1;
		for (int i = 0; i < burst_bytes; i++) begin
			offer_byte($urandom_range(0, 255));
		end
		valid = 1'b0;
		waited = 0;
		while (!seen_full && waited < 50) begin
			step();
			waited++;
		end
		if (!seen_full) begin
			stop_run("error_full never rose during the burst");
		end

		quiet = 0;
		waited = 0;
		last_rx = burst_rx;
		while (quiet < 300 && waited < 3000) begin
			step();
			waited++;
			if (burst_rx != last_rx) begin
				quiet = 0;
				last_rx = burst_rx;
			end else begin
				quiet++;
			end
		end
		if (quiet < 300) begin
			stop_run("timeout while waiting for the burst to drain");
		end

		if (burst_rx >= fifo_depth && burst_rx < burst_bytes && error_full) begin
			$display("TEST OK");
			$finish;
		end else begin
			stop_run("burst output count is off or error_full went low");
		end
	end

endmodule

`default_nettype wire
